// ==== bench/cache_tests.svh ====
// directed cache tests

// inputs change just after the edge
task automatic start_cycle();
  @(posedge clock);
  #1;
  rd_en = 1'b0;
  wr_en = 1'b0;
endtask

task automatic drive_read(input logic [set_bits-1:0] idx, input logic [tag_bits-1:0] tag);
  rd_en = 1'b1;
  rd_idx = idx;
  rd_tag = tag;
endtask

task automatic drive_write(input logic [set_bits-1:0] idx, input logic [tag_bits-1:0] tag,
                           input logic [data_bits-1:0] data, input logic dirty);
  wr_en = 1'b1;
  wr_idx = idx;
  wr_tag = tag;
  wr_data = data;
  wr_dirty = dirty;
endtask

// five distinct tags, low bits are the slot number
task automatic fill_set(input string name, input logic [set_bits-1:0] idx);
  logic [tag_bits-1:0] t;
  for (int i = 0; i < 5; i++) begin
    t = random_tag();
    slot_tag[i] = {t[7:3], 3'(i)};
    slot_data[i] = random_word();
  end
  for (int i = 0; i < 4; i++) begin
    start_cycle();
    drive_write(idx, slot_tag[i], slot_data[i], (i % 2) == 0);
    verify_outputs(name);
  end
endtask

task automatic reset_state_misses();
  for (int s = 0; s < num_sets; s++) begin
    start_cycle();
    drive_read(set_bits'(s), random_tag());
    verify_outputs("reset_state_misses");
    compare_flag("reset_state_misses", "rd_valid", 1'b0, rd_valid);
    compare_flag("reset_state_misses", "rd_miss_valid", 1'b1, rd_miss_valid);
  end
  start_cycle();
  drive_write(3'd0, random_tag(), random_word(), 1'b0);
  verify_outputs("reset_state_misses");
  compare_flag("reset_state_misses", "victim_valid", 1'b0, victim_valid);
endtask

task automatic write_then_read();
  logic [tag_bits-1:0]  tag;
  logic [data_bits-1:0] data;
  tag = random_tag();
  data = random_word();
  start_cycle();
  drive_write(3'd1, tag, data, 1'b0);
  verify_outputs("write_then_read");
  compare_flag("write_then_read", "wr_miss_valid", 1'b1, wr_miss_valid);
  start_cycle();
  drive_read(3'd1, tag);
  verify_outputs("write_then_read");
  compare_flag("write_then_read", "rd_valid", 1'b1, rd_valid);
  compare_flag("write_then_read", "rd_miss_valid", 1'b0, rd_miss_valid);
  compare_word("write_then_read", "rd_data", data, rd_data);
  start_cycle();
  drive_read(3'd1, tag ^ 8'h5a);
  verify_outputs("write_then_read");
  compare_flag("write_then_read", "rd_miss_valid", 1'b1, rd_miss_valid);
endtask

task automatic same_cycle_forwarding();
  logic [tag_bits-1:0]  tag;
  logic [data_bits-1:0] data;
  tag = random_tag();
  // tag not yet stored in set 2
  for (int i = 0; i < 2; i++) begin
    data = random_word();
    start_cycle();
    drive_write(3'd2, tag, data, 1'b1);
    drive_read(3'd2, tag);
    verify_outputs("same_cycle_forwarding");
    compare_flag("same_cycle_forwarding", "rd_valid", 1'b1, rd_valid);
    compare_word("same_cycle_forwarding", "rd_data", data, rd_data);
  end
endtask

task automatic write_hit_update();
  logic [tag_bits-1:0]  tag;
  logic [data_bits-1:0] data;
  tag = random_tag();
  start_cycle();
  drive_write(3'd3, tag, random_word(), 1'b0);
  verify_outputs("write_hit_update");
  data = random_word();
  start_cycle();
  drive_write(3'd3, tag, data, 1'b1);
  verify_outputs("write_hit_update");
  compare_flag("write_hit_update", "wr_miss_valid", 1'b0, wr_miss_valid);
  compare_flag("write_hit_update", "victim_valid", 1'b0, victim_valid);
  start_cycle();
  drive_read(3'd3, tag);
  verify_outputs("write_hit_update");
  compare_word("write_hit_update", "rd_data", data, rd_data);
endtask

// in a fresh set the fills land in ways 0, 2, 1, 3 and way 0 goes next
task automatic set_eviction();
  fill_set("set_eviction", 3'd4);
  start_cycle();
  drive_write(3'd4, slot_tag[4], slot_data[4], 1'b0);
  verify_outputs("set_eviction");
  compare_flag("set_eviction", "victim_valid", 1'b1, victim_valid);
  compare_word("set_eviction", "victim_tag", {56'd0, slot_tag[0]}, {56'd0, victim_tag});
  compare_word("set_eviction", "victim_data", slot_data[0], victim_data);
  compare_flag("set_eviction", "victim_dirty", 1'b1, victim_dirty);
endtask

// hits on ways 0 and 2 leave way 1, slot 2, as the victim
task automatic read_touch_order();
  fill_set("read_touch_order", 3'd5);
  start_cycle();
  drive_read(3'd5, slot_tag[0]);
  verify_outputs("read_touch_order");
  start_cycle();
  drive_read(3'd5, slot_tag[1]);
  verify_outputs("read_touch_order");
  start_cycle();
  drive_write(3'd5, slot_tag[4], slot_data[4], 1'b0);
  verify_outputs("read_touch_order");
  compare_word("read_touch_order", "victim_tag", {56'd0, slot_tag[2]}, {56'd0, victim_tag});
  compare_word("read_touch_order", "victim_data", slot_data[2], victim_data);
endtask

// ==== bench/cache_tb.sv ====
// cache storage testbench

`timescale 1ns/1ps

module cache_tb
  import cache_pkg::*;
();

  logic                 clock;
  logic                 reset;
  logic                 rd_en;
  logic [set_bits-1:0]  rd_idx;
  logic [tag_bits-1:0]  rd_tag;
  logic [data_bits-1:0] rd_data;
  logic                 rd_valid;
  logic                 rd_miss_valid;
  logic                 wr_en;
  logic [set_bits-1:0]  wr_idx;
  logic [tag_bits-1:0]  wr_tag;
  logic [data_bits-1:0] wr_data;
  logic                 wr_dirty;
  logic                 wr_miss_valid;
  logic                 victim_valid;
  logic [tag_bits-1:0]  victim_tag;
  logic [data_bits-1:0] victim_data;
  logic                 victim_dirty;

  // reference model state
  cache_line_t          model_line [num_sets][num_ways];
  logic [2:0]           model_plru [num_sets];

  logic [tag_bits-1:0]  slot_tag [5];
  logic [data_bits-1:0] slot_data [5];
  logic [31:0]          lfsr;
  int                   checks;
  int                   errors;

  cache_top uut (.*);

  always #50 clock = ~clock;

  // galois form, taps 32 22 2 1
  function automatic logic next_bit();
    logic out;
    out = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic logic [data_bits-1:0] random_word();
    logic [data_bits-1:0] d;
    d = '0;
    for (int i = 0; i < data_bits; i++) begin
      d = {d[data_bits-2:0], next_bit()};
    end
    return d;
  endfunction

  function automatic logic [tag_bits-1:0] random_tag();
    logic [tag_bits-1:0] t;
    t = '0;
    for (int i = 0; i < tag_bits; i++) begin
      t = {t[tag_bits-2:0], next_bit()};
    end
    return t;
  endfunction

  // returns {hit, way}
  function automatic logic [2:0] find_line(
    input logic [set_bits-1:0] idx,
    input logic [tag_bits-1:0] tag
  );
    for (int w = 0; w < num_ways; w++) begin
      if (model_line[idx][w].valid && (model_line[idx][w].tag == tag)) begin
        return {1'b1, 2'(w)};
      end
    end
    return 3'b000;
  endfunction

  // a set bit points to the upper half or the odd way
  function automatic logic [1:0] pick_victim(input logic [2:0] bits);
    if (bits[0] == 1'b0) begin
      return bits[1] ? 2'd1 : 2'd0;
    end
    return bits[2] ? 2'd3 : 2'd2;
  endfunction

  function automatic logic [2:0] touch_tree(input logic [2:0] bits, input logic [1:0] way);
    logic [2:0] n;
    n = bits;
    n[0] = (way < 2'd2);
    if (way < 2'd2) begin
      n[1] = (way[0] == 1'b0);
    end else begin
      n[2] = (way[0] == 1'b0);
    end
    return n;
  endfunction

  always @(posedge clock) begin : model_update
    logic       rd_hit;
    logic       wr_hit;
    logic [1:0] rd_way;
    logic [1:0] wr_way;
    if (reset) begin
      for (int s = 0; s < num_sets; s++) begin
        model_plru[s] = 3'b000;
        for (int w = 0; w < num_ways; w++) begin
          model_line[s][w] = '0;
        end
      end
    end else begin
      {rd_hit, rd_way} = find_line(rd_idx, rd_tag);
      {wr_hit, wr_way} = find_line(wr_idx, wr_tag);
      if (!wr_hit) begin
        wr_way = pick_victim(model_plru[wr_idx]);
      end
      if (wr_en) begin
        model_plru[wr_idx] = touch_tree(model_plru[wr_idx], wr_way);
      end
      // read last, only a stored hit counts
      if (rd_en && rd_hit) begin
        model_plru[rd_idx] = touch_tree(model_plru[rd_idx], rd_way);
      end
      if (wr_en) begin
        model_line[wr_idx][wr_way] = '{valid: 1'b1, dirty: wr_dirty,
                                       tag: wr_tag, data: wr_data};
      end
    end
  end

  task automatic compare_flag(input string name, input string what,
                              input logic expected, input logic actual);
    checks++;
    assert (actual === expected)
      else begin
        errors++;
        $display("** Error [%s] %s: expected %0b, actual %0b", name, what, expected, actual);
      end
  endtask

  task automatic compare_word(input string name, input string what,
                              input logic [63:0] expected, input logic [63:0] actual);
    checks++;
    assert (actual === expected)
      else begin
        errors++;
        $display("** Error [%s] %s: expected %h, actual %h", name, what, expected, actual);
      end
  endtask

  task automatic wait_settled(input string name);
    int steps;
    steps = 0;
    while ($isunknown({rd_valid, rd_miss_valid, wr_miss_valid, victim_valid}) && steps < 20) begin
      #1;
      steps++;
    end
    if ($isunknown({rd_valid, rd_miss_valid, wr_miss_valid, victim_valid})) begin
      errors++;
      $display("outputs in %s still unknown %0d ns after the settle delay", name, steps);
    end
  endtask

  // compare every output with what the model predicts for the driven inputs
  task automatic verify_outputs(input string name);
    logic [2:0]  rd_res;
    logic [2:0]  wr_res;
    logic        fwd;
    logic        exp_rd_valid;
    logic        exp_wr_miss;
    cache_line_t vic;
    #10;
    wait_settled(name);
    rd_res = find_line(rd_idx, rd_tag);
    wr_res = find_line(wr_idx, wr_tag);
    fwd = rd_en && wr_en && (rd_idx == wr_idx) && (rd_tag == wr_tag);
    exp_rd_valid = fwd || (rd_en && rd_res[2]);
    compare_flag(name, "rd_valid", exp_rd_valid, rd_valid);
    compare_flag(name, "rd_miss_valid", rd_en && !exp_rd_valid, rd_miss_valid);
    if (exp_rd_valid) begin
      compare_word(name, "rd_data", fwd ? wr_data : model_line[rd_idx][rd_res[1:0]].data,
                   rd_data);
    end
    exp_wr_miss = wr_en && !wr_res[2];
    vic = model_line[wr_idx][pick_victim(model_plru[wr_idx])];
    compare_flag(name, "wr_miss_valid", exp_wr_miss, wr_miss_valid);
    compare_flag(name, "victim_valid", exp_wr_miss && vic.valid, victim_valid);
    if (exp_wr_miss && vic.valid) begin
      compare_word(name, "victim_tag", {56'd0, vic.tag}, {56'd0, victim_tag});
      compare_word(name, "victim_data", vic.data, victim_data);
      compare_flag(name, "victim_dirty", vic.dirty, victim_dirty);
    end
  endtask

  `include "cache_tests.svh"

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    rd_en = 1'b0;
    rd_idx = '0;
    rd_tag = '0;
    wr_en = 1'b0;
    wr_idx = '0;
    wr_tag = '0;
    wr_data = '0;
    wr_dirty = 1'b0;
    lfsr = 32'ha803_f793;
    checks = 0;
    errors = 0;
    for (int i = 0; i < 5; i++) begin
      @(posedge clock);
    end
    #1;
    reset = 1'b0;
    reset_state_misses();
    write_then_read();
    same_cycle_forwarding();
    write_hit_update();
    set_eviction();
    read_touch_order();
    start_cycle();
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== hw/cache_ctrl.sv ====
// cache read and write control

`timescale 1ns/1ps

module cache_ctrl
  import cache_pkg::*;
(
  input  logic                 rd_en,
  input  logic [set_bits-1:0]  rd_idx,
  input  logic [tag_bits-1:0]  rd_tag,
  output logic [data_bits-1:0] rd_data,
  output logic                 rd_valid,
  output logic                 rd_miss_valid,

  input  logic                 wr_en,
  input  logic [set_bits-1:0]  wr_idx,
  input  logic [tag_bits-1:0]  wr_tag,
  input  logic [data_bits-1:0] wr_data,
  input  logic                 wr_dirty,
  output logic                 wr_miss_valid,

  output logic                 victim_valid,
  output cache_line_t          victim_line,

  lookup_if.ctrl               rd_look,
  lookup_if.ctrl               wr_look,
  fill_if.ctrl                 fill,

  output logic                 rd_touch_en,
  output logic [set_bits-1:0]  rd_touch_idx,
  output logic [way_bits-1:0]  rd_touch_way,
  output logic                 wr_touch_en,
  output logic [set_bits-1:0]  wr_touch_idx,
  output logic [way_bits-1:0]  wr_touch_way,

  output logic [set_bits-1:0]  victim_idx,
  input  logic [way_bits-1:0]  victim_way
);

  logic                rd_fwd;
  cache_line_t         rd_line;
  logic [way_bits-1:0] wr_way;

  assign rd_look.idx = rd_idx;
  assign rd_look.tag = rd_tag;
  assign wr_look.idx = wr_idx;
  assign wr_look.tag = wr_tag;

  // same-cycle write to the same line beats the store
  assign rd_fwd  = rd_en && wr_en && (wr_idx == rd_idx) && (wr_tag == rd_tag);
  assign rd_line = rd_look.lines[rd_look.hit_way];

  assign rd_data       = rd_fwd ? wr_data : rd_line.data;
  assign rd_valid      = rd_fwd || (rd_en && rd_look.hit);
  assign rd_miss_valid = rd_en && !rd_valid;

  // only a store hit refreshes the tree
  assign rd_touch_en  = rd_en && rd_look.hit;
  assign rd_touch_idx = rd_idx;
  assign rd_touch_way = rd_look.hit_way;

  // hit rewrites in place and a miss takes the tree's victim
  assign victim_idx    = wr_idx;
  assign wr_miss_valid = wr_en && !wr_look.hit;
  assign wr_way        = wr_look.hit ? wr_look.hit_way : victim_way;

  assign victim_line  = wr_look.lines[victim_way];
  assign victim_valid = wr_miss_valid && victim_line.valid;

  assign fill.fill_en         = wr_en;
  assign fill.fill_idx        = wr_idx;
  assign fill.fill_way        = wr_way;
  assign fill.fill_line.valid = 1'b1;
  assign fill.fill_line.dirty = wr_dirty;
  assign fill.fill_line.tag   = wr_tag;
  assign fill.fill_line.data  = wr_data;

  assign wr_touch_en  = wr_en;
  assign wr_touch_idx = wr_idx;
  assign wr_touch_way = wr_way;

  // an evicted line is never the one being written
  always_comb begin
    if (victim_valid) begin
      assert (victim_line.tag != wr_tag)
        else $error("cache_ctrl: victim holds the written tag");
    end
  end

endmodule

// ==== hw/cache_pkg.sv ====
// cache geometry and line types

package cache_pkg;

  // geometry
  localparam int num_sets  = 8;
  localparam int set_bits  = 3;
  localparam int num_ways  = 4;
  localparam int way_bits  = 2;
  localparam int tag_bits  = 8;
  localparam int data_bits = 64;

  // one tree bit per internal node
  localparam int plru_bits = num_ways - 1;

  // one stored line, valid in the top bit
  typedef struct packed {
    logic                 valid;
    logic                 dirty;
    logic [tag_bits-1:0]  tag;
    logic [data_bits-1:0] data;
  } cache_line_t;

  // all ways of a set, way 0 in the low bits
  typedef cache_line_t [num_ways-1:0] cache_set_t;

endpackage

// ==== hw/cache_top.sv ====
// data cache storage top

`timescale 1ns/1ps

module cache_top (
  input  logic                            clock,
  input  logic                            reset,

  input  logic                            rd_en,
  input  logic [cache_pkg::set_bits-1:0]  rd_idx,
  input  logic [cache_pkg::tag_bits-1:0]  rd_tag,
  output logic [cache_pkg::data_bits-1:0] rd_data,
  output logic                            rd_valid,
  output logic                            rd_miss_valid,

  input  logic                            wr_en,
  input  logic [cache_pkg::set_bits-1:0]  wr_idx,
  input  logic [cache_pkg::tag_bits-1:0]  wr_tag,
  input  logic [cache_pkg::data_bits-1:0] wr_data,
  input  logic                            wr_dirty,
  output logic                            wr_miss_valid,

  output logic                            victim_valid,
  output logic [cache_pkg::tag_bits-1:0]  victim_tag,
  output logic [cache_pkg::data_bits-1:0] victim_data,
  output logic                            victim_dirty
);

  lookup_if rd_lookup ();
  lookup_if wr_lookup ();
  fill_if   fill_bus ();

  cache_pkg::cache_line_t          victim_line;
  logic                            rd_touch_en;
  logic [cache_pkg::set_bits-1:0]  rd_touch_idx;
  logic [cache_pkg::way_bits-1:0]  rd_touch_way;
  logic                            wr_touch_en;
  logic [cache_pkg::set_bits-1:0]  wr_touch_idx;
  logic [cache_pkg::way_bits-1:0]  wr_touch_way;
  logic [cache_pkg::set_bits-1:0]  victim_idx;
  logic [cache_pkg::way_bits-1:0]  victim_way;

  line_store store (
    .clock   (clock),
    .reset   (reset),
    .rd_port (rd_lookup),
    .wr_port (wr_lookup),
    .fill    (fill_bus)
  );

  tag_match rd_match (.look(rd_lookup));
  tag_match wr_match (.look(wr_lookup));

  plru_tree plru (
    .clock        (clock),
    .reset        (reset),
    .rd_touch_en  (rd_touch_en),
    .rd_touch_idx (rd_touch_idx),
    .rd_touch_way (rd_touch_way),
    .wr_touch_en  (wr_touch_en),
    .wr_touch_idx (wr_touch_idx),
    .wr_touch_way (wr_touch_way),
    .victim_idx   (victim_idx),
    .victim_way   (victim_way)
  );

  cache_ctrl ctrl (
    .rd_en         (rd_en),
    .rd_idx        (rd_idx),
    .rd_tag        (rd_tag),
    .rd_data       (rd_data),
    .rd_valid      (rd_valid),
    .rd_miss_valid (rd_miss_valid),
    .wr_en         (wr_en),
    .wr_idx        (wr_idx),
    .wr_tag        (wr_tag),
    .wr_data       (wr_data),
    .wr_dirty      (wr_dirty),
    .wr_miss_valid (wr_miss_valid),
    .victim_valid  (victim_valid),
    .victim_line   (victim_line),
    .rd_look       (rd_lookup),
    .wr_look       (wr_lookup),
    .fill          (fill_bus),
    .rd_touch_en   (rd_touch_en),
    .rd_touch_idx  (rd_touch_idx),
    .rd_touch_way  (rd_touch_way),
    .wr_touch_en   (wr_touch_en),
    .wr_touch_idx  (wr_touch_idx),
    .wr_touch_way  (wr_touch_way),
    .victim_idx    (victim_idx),
    .victim_way    (victim_way)
  );

  // victim set is always wr_idx
  assign victim_tag   = victim_line.tag;
  assign victim_data  = victim_line.data;
  assign victim_dirty = victim_line.dirty;

endmodule

// ==== hw/fill_if.sv ====
// line write bundle

`timescale 1ns/1ps

interface fill_if
  import cache_pkg::*;
();

  logic                fill_en;
  logic [set_bits-1:0] fill_idx;
  logic [way_bits-1:0] fill_way;
  cache_line_t         fill_line;

  modport ctrl (
    output fill_en,
    output fill_idx,
    output fill_way,
    output fill_line
  );

  modport store (
    input fill_en,
    input fill_idx,
    input fill_way,
    input fill_line
  );

endinterface

// ==== hw/line_store.sv ====
// cache line store

`timescale 1ns/1ps

module line_store
  import cache_pkg::*;
(
  input logic       clock,
  input logic       reset,
  lookup_if.store   rd_port,
  lookup_if.store   wr_port,
  fill_if.store     fill
);

  cache_set_t [num_sets-1:0] sets;

  // both set reads are combinational
  assign rd_port.lines = sets[rd_port.idx];
  assign wr_port.lines = sets[wr_port.idx];

  always_ff @(posedge clock) begin
    if (reset) begin
      sets <= '0;
    end else if (fill.fill_en) begin
      sets[fill.fill_idx][fill.fill_way] <= fill.fill_line;
    end
  end

  // controller must hold off writes until reset is released
  assert property (@(posedge clock) reset |-> !fill.fill_en)
    else $error("line_store: fill while in reset");

endmodule

// ==== hw/lookup_if.sv ====
// set lookup bundle

`timescale 1ns/1ps

interface lookup_if
  import cache_pkg::*;
();

  logic [set_bits-1:0] idx;
  logic [tag_bits-1:0] tag;
  cache_set_t          lines;
  logic                hit;
  logic [way_bits-1:0] hit_way;

  modport store (
    input  idx,
    output lines
  );

  modport matcher (
    input  tag,
    input  lines,
    output hit,
    output hit_way
  );

  modport ctrl (
    output idx,
    output tag,
    input  lines,
    input  hit,
    input  hit_way
  );

endinterface

// ==== hw/plru_tree.sv ====
// tree pseudo-LRU state

`timescale 1ns/1ps

module plru_tree
  import cache_pkg::*;
(
  input  logic                clock,
  input  logic                reset,
  input  logic                rd_touch_en,
  input  logic [set_bits-1:0] rd_touch_idx,
  input  logic [way_bits-1:0] rd_touch_way,
  input  logic                wr_touch_en,
  input  logic [set_bits-1:0] wr_touch_idx,
  input  logic [way_bits-1:0] wr_touch_way,
  input  logic [set_bits-1:0] victim_idx,
  output logic [way_bits-1:0] victim_way
);

  logic [num_sets-1:0][plru_bits-1:0] tree;
  logic [num_sets-1:0][plru_bits-1:0] tree_next;

  // point the root and the covering node away from way w
  function automatic logic [plru_bits-1:0] touch(
    input logic [plru_bits-1:0] t,
    input logic [way_bits-1:0]  w
  );
    logic [plru_bits-1:0] n;
    n = t;
    n[0] = !w[1];
    if (!w[1]) begin
      n[1] = !w[0];
    end else begin
      n[2] = !w[0];
    end
    return n;
  endfunction

  // 1 leads to the upper half or odd way
  function automatic logic [way_bits-1:0] walk(input logic [plru_bits-1:0] t);
    logic [way_bits-1:0] w;
    w[1] = t[0];
    w[0] = t[0] ? t[2] : t[1];
    return w;
  endfunction

  // read touch last so it wins on shared bits
  always_comb begin
    tree_next = tree;
    if (wr_touch_en) begin
      tree_next[wr_touch_idx] = touch(tree_next[wr_touch_idx], wr_touch_way);
    end
    if (rd_touch_en) begin
      tree_next[rd_touch_idx] = touch(tree_next[rd_touch_idx], rd_touch_way);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      tree <= '0;
    end else begin
      tree <= tree_next;
    end
  end

  assign victim_way = walk(tree[victim_idx]);

endmodule

// ==== hw/tag_match.sv ====
// tag compare and hit encode

`timescale 1ns/1ps

module tag_match
  import cache_pkg::*;
(
  lookup_if.matcher look
);

  logic [num_ways-1:0] hits;
  logic [way_bits-1:0] way_enc;

  always_comb begin
    hits = '0;
    for (int w = 0; w < num_ways; w++) begin
      hits[w] = look.lines[w].valid && (look.lines[w].tag == look.tag);
    end
  end

  // OR of indices is exact for a one-hot vector
  always_comb begin
    way_enc = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (hits[w]) begin
        way_enc = way_enc | way_bits'(w);
      end
    end
  end

  assign look.hit     = |hits;
  assign look.hit_way = way_enc;

  // a set never holds the same valid tag twice
  always_comb begin
    if (!$isunknown(hits)) begin
      assert ($onehot0(hits))
        else $error("tag_match: tag present in more than one way");
    end
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f verilog.f --top-module cache_tb -o cache_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/cache_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$log"; then
  exit 1
fi
exit 0

// ==== verilog.f ====
+incdir+bench
hw/cache_pkg.sv
hw/lookup_if.sv
hw/fill_if.sv
hw/line_store.sv
hw/tag_match.sv
hw/plru_tree.sv
hw/cache_ctrl.sv
hw/cache_top.sv
bench/cache_tb.sv
